// File: common/bridge_pkg.sv
package bridge_pkg;

   // CAN identifier, top 4 bits function code, low 7 bits node number
   typedef logic [10:0] msg_id_t;
   typedef logic [31:0] msg_data_t;   // Message payload
   typedef logic [3:0]  func_code_t;  // Function code field of an ID

   // Bridge controller states
   typedef enum logic [4:0] {
      reset_st, start_st, initialize_st, signon_st,      // Reset and start-up
      wait_act_st,                                       // Idle
      prev_mes_st, idcomp_busy_st, idcomp_idle_st, abort_st,
      read_new_st, pass_co_st, rst_rec_irq_st,           // Receive path
      read_co_st, write_can_st, send_st, wait_tra_st, rst_all_irq_st,
      endwait_st, rst_rec_irq_low_st                     // Exits without a send
   } bridge_state_t;

   // ------------------------------
   // Function codes
   // ------------------------------
   localparam func_code_t fc_nmt         = 4'h0;  // NMT, ID zero means general reset
   localparam func_code_t fc_bootup      = 4'he;  // Boot-up message
   localparam func_code_t fc_resp_offset = 4'h8;  // Request code plus this gives response code

endpackage

// File: common/obj_bus_if.sv
`timescale 1ns/1ps

// One message between dispatcher, handler and collector
interface obj_bus_if import bridge_pkg::*; ();

   logic      wr;     // Request strobe, or response ready on the response side
   msg_id_t   id;     // Message ID
   msg_data_t data;   // Payload
   logic      abort;  // Drop the current job

   // Sending side
   modport src (
      output wr,
      output id,
      output data,
      output abort
   );

   // Receiving side
   modport dst (
      input wr,
      input id,
      input data,
      input abort
   );

endinterface

// File: bridge_ctrl/bridge_ctrl.sv
`timescale 1ns/1ps

module bridge_ctrl import bridge_pkg::*; #(
   parameter int TIMEOUT_CYC = 64   // Watchdog limit in cycles
) (
   input  logic clk,
   input  logic rst,
   input  logic end_init,        // CAN node init finished
   input  logic can_rx_irq,      // New frame received
   input  logic can_tx_irq,      // Transmission finished
   input  logic co_busy,         // Some handler still processing
   input  logic irq_co,          // Some handler has a response
   input  logic idcmpdone,
   input  logic highpr,
   input  logic lowpr,
   input  logic genrst,
   input  logic end_read_can,
   input  logic end_write_co,
   input  logic end_read_co,
   input  logic end_write_can,
   input  logic endwait,         // Frame matched no handler
   output logic init,
   output logic abort_mes,
   output logic id_comp,
   output logic start_read_can,
   output logic start_write_co,
   output logic start_read_co,
   output logic start_write_can,
   output logic send_mes_can,
   output logic reset_irq_can,
   output logic signonsig        // Boot-up message select
);

   localparam int WD_W = $clog2(TIMEOUT_CYC + 1);

   bridge_state_t state, next_state;
   logic          entimeout;    // Watchdog enable
   logic [WD_W-1:0] wd_cnt;
   logic          wd_expire;

   // ------------------------------
   // Next state
   // ------------------------------
   always_comb begin
      next_state = state;   // Hold by default
      case (state)
         reset_st:       next_state = start_st;
         start_st:       next_state = initialize_st;
         initialize_st:  if (end_init) next_state = signon_st;
         signon_st:      if (end_read_co) next_state = write_can_st;  // Boot-up picked up
         wait_act_st: begin
            if (can_rx_irq)
               next_state = prev_mes_st;   // Receive has priority
            else if (irq_co)
               next_state = read_co_st;
         end
         prev_mes_st:    next_state = co_busy ? idcomp_busy_st : idcomp_idle_st;
         idcomp_busy_st: begin
            if (idcmpdone && genrst)
               next_state = reset_st;
            else if (idcmpdone && highpr)
               next_state = abort_st;      // New frame wins
            else if (idcmpdone && lowpr)
               next_state = rst_rec_irq_low_st;   // New frame dropped
         end
         idcomp_idle_st: begin
            if (idcmpdone && genrst)
               next_state = reset_st;
            else if (idcmpdone)
               next_state = read_new_st;
         end
         abort_st:       next_state = read_new_st;
         read_new_st:    if (end_read_can) next_state = pass_co_st;
         pass_co_st:     if (end_write_co) next_state = rst_rec_irq_st;
         rst_rec_irq_st: next_state = wait_act_st;
         read_co_st:     if (end_read_co) next_state = write_can_st;
         write_can_st:   if (end_write_can) next_state = send_st;
         send_st:        next_state = wait_tra_st;
         wait_tra_st:    if (can_tx_irq) next_state = rst_all_irq_st;  // Only back-pressure point
         rst_all_irq_st: next_state = wait_act_st;
         endwait_st:     next_state = rst_rec_irq_st;
         rst_rec_irq_low_st: next_state = wait_act_st;
         default:        next_state = reset_st;
      endcase
   end

   // ------------------------------
   // State register
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst)
         state <= reset_st;
      else if (wd_expire)
         state <= reset_st;     // Stuck too long
      else if (endwait)
         state <= endwait_st;   // Undecodable frame overrides
      else
         state <= next_state;
   end

   // Watchdog, cleared whenever the bridge is idle or resetting
   always_ff @(posedge clk) begin
      if (rst || !entimeout || wd_expire)
         wd_cnt <= '0;
      else
         wd_cnt <= wd_cnt + 1'b1;
   end

   assign wd_expire = (wd_cnt == WD_W'(TIMEOUT_CYC));

   // ------------------------------
   // Output decode, one-hot per state
   // ------------------------------
   always_comb begin
      init            = 1'b0;
      abort_mes       = 1'b0;
      id_comp         = 1'b0;
      start_read_can  = 1'b0;
      start_write_co  = 1'b0;
      start_read_co   = 1'b0;
      start_write_can = 1'b0;
      send_mes_can    = 1'b0;
      reset_irq_can   = 1'b0;
      signonsig       = 1'b0;
      entimeout       = 1'b1;
      case (state)
         reset_st: begin
            abort_mes = 1'b1;   // Clear all blocks
            entimeout = 1'b0;
         end
         initialize_st: begin
            init      = 1'b1;
            entimeout = 1'b0;   // CAN node may take its time
         end
         wait_act_st:    entimeout = 1'b0;
         signon_st: begin
            signonsig     = 1'b1;
            start_read_co = 1'b1;
         end
         idcomp_busy_st, idcomp_idle_st: id_comp = 1'b1;
         abort_st:       abort_mes = 1'b1;
         read_new_st:    start_read_can = 1'b1;
         pass_co_st:     start_write_co = 1'b1;
         read_co_st:     start_read_co = 1'b1;
         write_can_st:   start_write_can = 1'b1;
         send_st:        send_mes_can = 1'b1;
         rst_rec_irq_st, rst_all_irq_st, rst_rec_irq_low_st: reset_irq_can = 1'b1;
         default: ;     // start_st, prev_mes_st, wait_tra_st, endwait_st
      endcase
   end

endmodule

// File: bridge_ctrl/rx_buffer.sv
`timescale 1ns/1ps

module rx_buffer import bridge_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      abort_mes,       // Drops the held message
   input  msg_id_t   can_rx_id,       // Frame at the CAN receive registers
   input  msg_data_t can_rx_data,
   input  logic      id_comp,
   input  logic      start_read_can,
   output msg_id_t   buf_id,          // Buffered message
   output msg_data_t buf_data,
   output logic      idcmpdone,
   output logic      highpr,
   output logic      lowpr,
   output logic      genrst,
   output logic      end_read_can
);

   logic       held;      // A message is still in progress
   logic       rd_go;
   logic       cmp_go;
   func_code_t new_fc;
   logic       new_zero;  // General reset frame
   logic       new_lower;

   assign rd_go  = start_read_can && !end_read_can;   // First cycle of the strobe
   assign cmp_go = id_comp && !idcmpdone;
   assign new_fc = can_rx_id[10:7];
   assign new_zero  = (new_fc == fc_nmt) && (can_rx_id[6:0] == '0);
   assign new_lower = !held || (can_rx_id < buf_id);   // Lower ID wins

   // Frame latch
   always_ff @(posedge clk) begin
      if (rd_go) begin
         buf_id   <= can_rx_id;
         buf_data <= can_rx_data;
      end
   end

   // ------------------------------
   // Control and compare result
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         held         <= 1'b0;
         end_read_can <= 1'b0;
         idcmpdone    <= 1'b0;
         highpr       <= 1'b0;
         lowpr        <= 1'b0;
         genrst       <= 1'b0;
      end else begin
         end_read_can <= rd_go;
         idcmpdone    <= cmp_go;            // One cycle after id_comp
         genrst       <= cmp_go && new_zero;
         highpr       <= cmp_go && !new_zero && new_lower;
         lowpr        <= cmp_go && !new_zero && !new_lower;
         if (abort_mes)
            held <= 1'b0;
         if (rd_go)
            held <= 1'b1;                  // New job takes over
      end
   end

endmodule

// File: design/obj_dispatch.sv
`timescale 1ns/1ps

module obj_dispatch import bridge_pkg::*; #(
   parameter int NUM_OBJ = 4
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      start_write_co,
   input  logic      abort_mes,
   input  msg_id_t   buf_id,
   input  msg_data_t buf_data,
   output logic      end_write_co,
   output logic      endwait,         // No handler serves this code
   obj_bus_if.src    obj [NUM_OBJ]    // One request bus per handler
);

   logic [NUM_OBJ-1:0] wr_q;          // Per-handler write strobes
   logic               go;
   logic               match;
   func_code_t         fc;

   assign fc    = buf_id[10:7];
   assign go    = start_write_co && !end_write_co && !endwait;
   // Handler k serves code k+1
   assign match = (fc != '0) && (fc <= func_code_t'(NUM_OBJ));

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_q         <= '0;
         end_write_co <= 1'b0;
         endwait      <= 1'b0;
      end else begin
         end_write_co <= go && match;
         endwait      <= go && !match;
         for (int k = 0; k < NUM_OBJ; k++)
            wr_q[k] <= go && (fc == func_code_t'(k + 1));
      end
   end

   // ------------------------------
   // Fan out to the handlers
   // ------------------------------
   for (genvar k = 0; k < NUM_OBJ; k++) begin : g_bus
      assign obj[k].wr    = wr_q[k];
      assign obj[k].id    = buf_id;      // Buffer stays stable until next read
      assign obj[k].data  = buf_data;
      assign obj[k].abort = abort_mes;
   end

endmodule

// File: design/co_object.sv
`timescale 1ns/1ps

module co_object import bridge_pkg::*; #(
   parameter int         OBJ_LAT = 3,      // Processing delay, at least 2
   parameter func_code_t OBJ_FC  = 4'h1    // Served function code
) (
   input  logic   clk,
   input  logic   rst,
   input  logic   ack,        // Response taken by the collector
   output logic   busy,
   obj_bus_if.dst req,
   obj_bus_if.src resp
);

   localparam int         CNT_W   = $clog2(OBJ_LAT + 1);
   localparam func_code_t RESP_FC = OBJ_FC + fc_resp_offset;

   logic [CNT_W-1:0] cnt;     // Cycles left
   logic             ready;   // Response held for collection
   logic [6:0]       node_q;
   msg_data_t        data_q;

   // Request payload
   always_ff @(posedge clk) begin
      if (req.wr) begin
         node_q <= req.id[6:0];
         data_q <= req.data;
      end
   end

   // ------------------------------
   // Processing delay
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst || req.abort) begin
         busy  <= 1'b0;
         ready <= 1'b0;
         cnt   <= '0;
      end else if (req.wr) begin
         busy  <= 1'b1;
         ready <= 1'b0;                  // A new request replaces an old response
         cnt   <= CNT_W'(OBJ_LAT - 1);
      end else if (busy) begin
         cnt <= cnt - 1'b1;
         if (cnt == CNT_W'(1)) begin
            busy  <= 1'b0;
            ready <= 1'b1;               // OBJ_LAT cycles after wr
         end
      end else if (ack) begin
         ready <= 1'b0;
      end
   end

   // Response: code plus offset, same node, data plus one
   assign resp.wr    = ready;
   assign resp.id    = {RESP_FC, node_q};
   assign resp.data  = data_q + 32'd1;
   assign resp.abort = req.abort;        // Response about to be cleared

endmodule

// File: design/tx_collect.sv
`timescale 1ns/1ps

module tx_collect import bridge_pkg::*; #(
   parameter int         NUM_OBJ = 4,
   parameter logic [6:0] NODE_ID = 7'h21
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               start_read_co,
   input  logic               start_write_can,
   input  logic               signonsig,      // Take the boot-up message
   output logic               irq_co,
   output logic               end_read_co,
   output logic               end_write_can,
   output msg_id_t            can_tx_id,      // CAN transmit registers
   output msg_data_t          can_tx_data,
   output logic [NUM_OBJ-1:0] ack,
   obj_bus_if.dst             resp [NUM_OBJ]
);

   logic [NUM_OBJ-1:0] rdy;
   msg_id_t            rsp_id   [NUM_OBJ];
   msg_data_t          rsp_data [NUM_OBJ];
   msg_id_t            pick_id, hold_id;      // Selected message and its holding copy
   msg_data_t          pick_data, hold_data;
   logic [NUM_OBJ-1:0] pick_ack;
   logic               rd_go, wr_go;

   for (genvar k = 0; k < NUM_OBJ; k++) begin : g_rsp
      assign rdy[k]      = resp[k].wr && !resp[k].abort;
      assign rsp_id[k]   = resp[k].id;
      assign rsp_data[k] = resp[k].data;
   end

   assign irq_co = |rdy;
   assign rd_go  = start_read_co && !end_read_co;
   assign wr_go  = start_write_can && !end_write_can;

   // ------------------------------
   // Lowest index ready wins
   // ------------------------------
   always_comb begin
      pick_id   = {fc_bootup, NODE_ID};   // Boot-up, zero data
      pick_data = '0;
      pick_ack  = '0;
      if (!signonsig) begin
         for (int k = NUM_OBJ - 1; k >= 0; k--) begin
            if (rdy[k]) begin
               pick_id     = rsp_id[k];
               pick_data   = rsp_data[k];
               pick_ack    = '0;
               pick_ack[k] = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_go) begin
         hold_id   <= pick_id;
         hold_data <= pick_data;
      end
      if (wr_go) begin
         can_tx_id   <= hold_id;
         can_tx_data <= hold_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ack           <= '0;
         end_read_co   <= 1'b0;
         end_write_can <= 1'b0;
      end else begin
         ack           <= rd_go ? pick_ack : '0;   // Releases the handler
         end_read_co   <= rd_go;
         end_write_can <= wr_go;
      end
   end

endmodule

// File: design/can_bridge_top.sv
`timescale 1ns/1ps

module can_bridge_top import bridge_pkg::*; #(
   parameter int         NUM_OBJ     = 4,
   parameter int         OBJ_LAT     = 3,
   parameter int         TIMEOUT_CYC = 64,
   parameter logic [6:0] NODE_ID     = 7'h21
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      end_init,
   input  logic      can_rx_irq,
   input  logic      can_tx_irq,
   input  msg_id_t   can_rx_id,
   input  msg_data_t can_rx_data,
   output logic      init,
   output logic      send_mes_can,
   output logic      reset_irq_can,
   output logic      abort_mes,
   output msg_id_t   can_tx_id,
   output msg_data_t can_tx_data,
   output logic      boot_done
);

   logic co_busy, irq_co, id_comp, idcmpdone, highpr, lowpr, genrst, endwait, signonsig;
   logic start_read_can, end_read_can, start_write_co, end_write_co;
   logic start_read_co, end_read_co, start_write_can, end_write_can;
   logic [NUM_OBJ-1:0] obj_busy;
   logic [NUM_OBJ-1:0] obj_ack;
   msg_id_t   buf_id;
   msg_data_t buf_data;

   obj_bus_if req_bus  [NUM_OBJ] ();   // Dispatcher to handlers
   obj_bus_if resp_bus [NUM_OBJ] ();   // Handlers to collector

   bridge_ctrl #(.TIMEOUT_CYC(TIMEOUT_CYC)) ctrl_i (.*);

   rx_buffer rxbuf_i (.*);

   obj_dispatch #(.NUM_OBJ(NUM_OBJ)) disp_i (
      .clk, .rst, .start_write_co, .abort_mes, .buf_id, .buf_data,
      .end_write_co, .endwait,
      .obj (req_bus)
   );

   // ------------------------------
   // Handlers, k serves code k+1
   // ------------------------------
   for (genvar k = 0; k < NUM_OBJ; k++) begin : g_obj
      co_object #(.OBJ_LAT(OBJ_LAT), .OBJ_FC(func_code_t'(k + 1))) obj_i (
         .clk, .rst,
         .ack  (obj_ack[k]),
         .busy (obj_busy[k]),
         .req  (req_bus[k]),
         .resp (resp_bus[k])
      );
   end

   assign co_busy = |obj_busy;

   tx_collect #(.NUM_OBJ(NUM_OBJ), .NODE_ID(NODE_ID)) txc_i (
      .clk, .rst, .start_read_co, .start_write_can, .signonsig,
      .irq_co, .end_read_co, .end_write_can, .can_tx_id, .can_tx_data,
      .ack  (obj_ack),
      .resp (resp_bus)
   );

   // Set by the first send, which is always the boot-up message
   always_ff @(posedge clk) begin
      if (rst)
         boot_done <= 1'b0;
      else if (send_mes_can)
         boot_done <= 1'b1;
   end

endmodule

// File: bench/tb_can_bridge.sv
`timescale 1ns/1ps

module tb_can_bridge import bridge_pkg::*; ();

   localparam int         N_TESTS = 11;
   localparam int         LIMIT   = N_TESTS * 200;   // Cycle budget for the whole run
   localparam logic [6:0] NODE_ID = 7'h21;
   localparam int         QUIET   = 40;              // Idle cycles checked after each entry
   localparam int         K_FRAME = 0;               // Entry kinds
   localparam int         K_GENRST = 1;
   localparam int         K_WDOG  = 2;

   logic      clk;
   logic      rst;
   logic      end_init   = 1'b0;
   logic      can_rx_irq;
   logic      can_tx_irq = 1'b0;
   msg_id_t   can_rx_id;
   msg_data_t can_rx_data;
   logic      init, send_mes_can, reset_irq_can, abort_mes, boot_done;
   msg_id_t   can_tx_id;
   msg_data_t can_tx_data;

   logic      hold_tx = 1'b0;      // CAN model withholds can_tx_irq
   logic      init_seen = 1'b0;    // Outputs sampled mid-cycle
   logic      send_seen = 1'b0;
   int        tx_cnt = 0;
   int        cycle_cnt = 0;

   // Stimulus table
   string     t_name [N_TESTS];
   int        t_kind [N_TESTS];
   msg_id_t   t_id   [N_TESTS];
   msg_data_t t_data [N_TESTS];
   logic      t_chain [N_TESTS];   // Next entry follows at once without a send wait
   logic      t_send [N_TESTS];
   logic      t_abort [N_TESTS];
   msg_id_t   t_exp_id [N_TESTS];
   msg_data_t t_exp_data [N_TESTS];

   // Longer handler delay so a second frame meets a busy handler
   can_bridge_top #(.OBJ_LAT(12)) dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ------------------------------
   // CAN node model
   // ------------------------------
   always @(negedge clk) begin
      init_seen <= init;
      send_seen <= send_mes_can;
   end

   always @(posedge clk) begin
      end_init <= init_seen && !rst;       // Init done one cycle later
      if (send_seen && !hold_tx)
         tx_cnt <= 3;                      // Frame goes out a few cycles later
      else if (tx_cnt != 0)
         tx_cnt <= tx_cnt - 1;
      can_tx_irq <= (tx_cnt == 1);
   end

   // Run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= LIMIT) begin
         $display("Run took longer than %0d cycles, the bridge stopped responding", LIMIT);
         $display("tests failed");
         $fatal(1, "timeout");
      end
   end

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_id(input string name, input msg_id_t exp, input msg_id_t act);
      if (exp !== act) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         $display("tests failed");
         $fatal(1, "id mismatch");
      end
   endtask

   task automatic check_data(input string name, input msg_data_t exp, input msg_data_t act);
      if (exp !== act) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         $display("tests failed");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("ERR %s: expected %b, actual %b", name, exp, act);
         $display("tests failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic set_entry(input int i, input string name, input int kind, input msg_id_t id,
                            input msg_data_t data, input logic chain, input logic send,
                            input logic abort, input msg_id_t exp_id, input msg_data_t exp_data);
      t_name[i]     = name;
      t_kind[i]     = kind;
      t_id[i]       = id;
      t_data[i]     = data;
      t_chain[i]    = chain;
      t_send[i]     = send;
      t_abort[i]    = abort;
      t_exp_id[i]   = exp_id;
      t_exp_data[i] = exp_data;
   endtask

   // Responses carry code plus 8 with the same node and data plus one
   task automatic load_table();
      set_entry(0, "req_fc1", K_FRAME, {4'h1, 7'h10}, 32'h1234_5678, 0, 1, 0,
                {4'h9, 7'h10}, 32'h1234_5679);
      set_entry(1, "req_fc2", K_FRAME, {4'h2, 7'h22}, 32'hffff_ffff, 0, 1, 0,
                {4'ha, 7'h22}, 32'h0000_0000);
      set_entry(2, "req_fc3", K_FRAME, {4'h3, 7'h01}, 32'h0000_00a5, 0, 1, 0,
                {4'hb, 7'h01}, 32'h0000_00a6);
      set_entry(3, "req_fc4", K_FRAME, {4'h4, 7'h7f}, 32'h8000_0000, 0, 1, 0,
                {4'hc, 7'h7f}, 32'h8000_0001);
      set_entry(4, "unmatched", K_FRAME, {4'h5, 7'h11}, 32'h0000_0001, 0, 0, 0, '0, '0);
      set_entry(5, "high_first", K_FRAME, {4'h3, 7'h10}, 32'h0000_0100, 1, 0, 0, '0, '0);
      set_entry(6, "high_second", K_FRAME, {4'h2, 7'h05}, 32'h0000_0200, 0, 1, 1,
                {4'ha, 7'h05}, 32'h0000_0201);
      set_entry(7, "low_first", K_FRAME, {4'h1, 7'h10}, 32'h0000_0300, 1, 0, 0, '0, '0);
      set_entry(8, "low_second", K_FRAME, {4'h4, 7'h07}, 32'h0000_0400, 0, 1, 0,
                {4'h9, 7'h10}, 32'h0000_0301);
      set_entry(9, "general_reset", K_GENRST, '0, 32'h0, 0, 1, 1, '0, '0);
      set_entry(10, "watchdog", K_WDOG, {4'h2, 7'h33}, 32'h0000_0055, 0, 1, 0,
                {4'ha, 7'h33}, 32'h0000_0056);
   endtask

   // ------------------------------
   // Sequencing helpers
   // ------------------------------
   task automatic expect_send(input string name, input msg_id_t exp_id, input msg_data_t exp_data);
      do @(negedge clk); while (!send_mes_can);
      check_id({name, " tx id"}, exp_id, can_tx_id);
      check_data({name, " tx data"}, exp_data, can_tx_data);
   endtask

   task automatic expect_quiet(input string name);
      repeat (QUIET) begin
         @(negedge clk);
         check_bit({name, " no extra send"}, 1'b0, send_mes_can);
      end
   endtask

   task automatic expect_boot(input string name);
      do @(negedge clk); while (!init);   // CAN node init requested
      expect_send({name, " boot-up"}, {fc_bootup, NODE_ID}, '0);
      @(negedge clk);
      check_bit({name, " boot_done"}, 1'b1, boot_done);
   endtask

   task automatic wait_abort();
      do @(negedge clk); while (!abort_mes);
   endtask

   // Presents a frame and waits until the bridge clears its interrupt
   task automatic post_frame(input int i);
      logic abort_seen;
      abort_seen = 1'b0;
      @(posedge clk);
      can_rx_id   <= t_id[i];
      can_rx_data <= t_data[i];
      can_rx_irq  <= 1'b1;
      do begin
         @(negedge clk);
         if (abort_mes)
            abort_seen = 1'b1;
      end while (!reset_irq_can);
      @(posedge clk);
      can_rx_irq <= 1'b0;
      check_bit({t_name[i], " abort"}, t_abort[i], abort_seen);
   endtask

   task automatic run_entry(input int i);
      if (t_kind[i] == K_GENRST) begin
         @(posedge clk);
         can_rx_id   <= t_id[i];
         can_rx_data <= t_data[i];
         can_rx_irq  <= 1'b1;
         wait_abort();
         @(posedge clk);
         can_rx_irq <= 1'b0;             // Else the reset frame repeats
         expect_boot(t_name[i]);
         expect_quiet(t_name[i]);
      end else if (t_kind[i] == K_WDOG) begin
         @(posedge clk);
         hold_tx <= 1'b1;                // Transmission never completes
         post_frame(i);
         expect_send(t_name[i], t_exp_id[i], t_exp_data[i]);
         wait_abort();
         @(posedge clk);
         hold_tx <= 1'b0;
         expect_boot(t_name[i]);
         expect_quiet(t_name[i]);
      end else begin
         post_frame(i);
         if (!t_chain[i]) begin
            if (t_send[i])
               expect_send(t_name[i], t_exp_id[i], t_exp_data[i]);
            expect_quiet(t_name[i]);
         end
      end
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      rst         = 1'b1;
      can_rx_irq  = 1'b0;
      can_rx_id   = '0;
      can_rx_data = '0;
      load_table();
      repeat (15) @(posedge clk);
      @(negedge clk);
      // Outputs held in their reset state
      check_bit("reset init", 1'b0, init);
      check_bit("reset abort_mes", 1'b1, abort_mes);
      check_bit("reset send_mes_can", 1'b0, send_mes_can);
      check_bit("reset reset_irq_can", 1'b0, reset_irq_can);
      check_bit("reset boot_done", 1'b0, boot_done);
      @(posedge clk);
      rst <= 1'b0;
      expect_boot("power_up");
      expect_quiet("power_up");
      for (int i = 0; i < N_TESTS; i++)
         run_entry(i);
      $display("all tests passed");
      $finish;
   end

endmodule

// File: project.f
common/bridge_pkg.sv
common/obj_bus_if.sv
bridge_ctrl/bridge_ctrl.sv
bridge_ctrl/rx_buffer.sv
design/obj_dispatch.sv
design/co_object.sv
design/tx_collect.sv
design/can_bridge_top.sv
bench/tb_can_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_can_bridge -f project.f \
   --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "all tests passed" sim.log; then
   exit 0
else
   exit 1
fi
